//--- verilog/shotSettings.svh
`ifndef SHOT_SETTINGS_SVH
`define SHOT_SETTINGS_SVH

// screen size in pixels
// an inactive shot is parked at the bottom right corner, off screen
`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 480

// launch point, top left corner of the shot box in pixels
`define SHOT_START_X 280
`define SHOT_START_Y 185

// per frame steps, in 1/64 pixel units
`define SHOT_SPEED_X 40	// sideways drift
`define SHOT_SPEED_Y 320	// upward, 5 pixels per frame

// fixed point uses 2**FIXED_SHIFT sub units per pixel
`define FIXED_SHIFT 6

// side length of the shot box and of the target box
`define OBJECT_SIZE 32

// pixel y below this means the shot has left the top edge
// the whole box is then above the visible area
`define EXIT_Y (-32)

`endif

//--- verilog/shotPkg.sv
package shotPkg;

	// pixel coordinate, signed so a shot can sit above the top edge
	typedef logic signed [10:0] coordT;

	// fixed point coordinate, pixel value times 64
	// 18 bits covers the park position 640*64 with the sign bit spare
	typedef logic signed [17:0] fixedT;

	// hit counter, saturates at the top
	typedef logic [7:0] scoreT;

	// launch direction from the button pair
	typedef enum logic [1:0] {
		dirStraight,	// no drift
		dirRight,	// x grows each frame
		dirLeft	// x shrinks each frame
	} dirT;

	// decode stage state
	typedef enum logic {
		fireIdle,	// nothing waiting
		firePending	// a press waits for the next frame
	} fireStateT;

endpackage

//--- verilog/shotIf.sv
`timescale 1ns/1ps

// signals between decode, execute and result stages
interface shotIf
	import shotPkg::*;
();

	logic	deploy;	// launch strobe, frame cycle only
	dirT	direction;	// drift chosen with the launch
	coordT	shotX;	// shot top left corner, pixels
	coordT	shotY;
	logic	active;	// a shot is flying
	logic	collision;	// shot box met target box, frame cycle only

	// decode stage launches only when no shot is flying
	modport fire (
		output	deploy,
		output	direction,
		input	active
	);

	// execute stage owns the position
	modport motion (
		input	deploy,
		input	direction,
		input	collision,
		output	shotX,
		output	shotY,
		output	active
	);

	// result stage reads the shot box
	modport hit (
		input	shotX,
		input	shotY,
		input	active,
		output	collision
	);

endinterface

//--- verilog/fireControl.sv
`timescale 1ns/1ps
`include "shotSettings.svh"

// decode stage
// a fire press is held until the next frame tick, then launched or dropped
module fireControl
	import shotPkg::*;
(
	input	logic	clk,
	input	logic	resetN,
	input	logic	startOfFrame,	// one cycle tick per frame
	input	logic	fireButton,
	input	logic	leftButton,
	input	logic	rightButton,
	shotIf.fire	fire
);

fireStateT state;
fireStateT nextState;
logic prevFire;	// fire level one cycle ago
logic fireRise;	// press detected this cycle

assign fireRise = fireButton && !prevFire;

always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		state <= fireIdle;
		prevFire <= 1'b0;
	end
	else begin
		state <= nextState;
		prevFire <= fireButton;	// edge detect history
	end
end

// the frame tick always consumes a pending request
// launched if the screen is free, otherwise thrown away
always_comb begin
	nextState = state;
	fire.deploy = 1'b0;
	case (state)
		fireIdle: begin
			if (fireRise)
				nextState = firePending;
		end
		firePending: begin
			if (startOfFrame) begin
				fire.deploy = !fire.active;	// no second shot in flight
				// a fresh press in the tick cycle waits for the next frame
				nextState = fireRise ? firePending : fireIdle;
			end
		end
		default: nextState = fireIdle;
	endcase
end

// direction follows the buttons in the launch cycle
always_comb begin
	case ({leftButton, rightButton})
		2'b01: fire.direction = dirRight;
		2'b10: fire.direction = dirLeft;
		default: fire.direction = dirStraight;	// both or neither
	endcase
end

endmodule

//--- verilog/shotLogic.sv
`timescale 1ns/1ps
`include "shotSettings.svh"

// execute stage
// integrates the shot position in 1/64 pixel units, once per frame
module shotLogic
	import shotPkg::*;
(
	input	logic	clk,
	input	logic	resetN,
	input	logic	startOfFrame,	// one cycle tick per frame
	shotIf.motion	motion
);

// fixed point versions of the screen constants
localparam fixedT parkX = fixedT'(`SCREEN_WIDTH << `FIXED_SHIFT);
localparam fixedT parkY = fixedT'(`SCREEN_HEIGHT << `FIXED_SHIFT);
localparam fixedT startX = fixedT'(`SHOT_START_X << `FIXED_SHIFT);
localparam fixedT startY = fixedT'(`SHOT_START_Y << `FIXED_SHIFT);
localparam fixedT stepX = fixedT'(`SHOT_SPEED_X);
localparam fixedT stepY = fixedT'(`SHOT_SPEED_Y);
localparam coordT exitY = coordT'(`EXIT_Y);

fixedT posX;	// top left corner in fixed point
fixedT posY;
fixedT speedX;	// signed drift chosen at launch
fixedT launchSpeed;
fixedT nextX;
fixedT nextY;
coordT nextPixY;	// pixel y after this frame's move
logic flying;
logic exitTop;

// candidate position for an active shot
assign nextX = posX + speedX;
assign nextY = posY - stepY;	// screen y grows downward
assign nextPixY = coordT'(nextY >>> `FIXED_SHIFT);
assign exitTop = nextPixY < exitY;	// checked on the new value

always_comb begin
	case (motion.direction)
		dirRight: launchSpeed = stepX;
		dirLeft: launchSpeed = -stepX;
		default: launchSpeed = '0;
	endcase
end

// priority order is collision, launch, move, hold
always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		posX <= parkX;	// start parked off screen
		posY <= parkY;
		speedX <= '0;
		flying <= 1'b0;
	end
	else if (startOfFrame) begin
		if (motion.collision) begin
			posX <= parkX;
			posY <= parkY;
			flying <= 1'b0;
		end
		else if (motion.deploy) begin
			posX <= startX;
			posY <= startY;
			speedX <= launchSpeed;	// drift for the whole flight
			flying <= 1'b1;
		end
		else if (flying) begin
			if (exitTop) begin	// gone past the top edge
				posX <= parkX;
				posY <= parkY;
				flying <= 1'b0;
			end
			else begin
				posX <= nextX;
				posY <= nextY;
			end
		end
	end
end

// arithmetic shift drops the fraction and keeps the sign
assign motion.shotX = coordT'(posX >>> `FIXED_SHIFT);
assign motion.shotY = coordT'(posY >>> `FIXED_SHIFT);
assign motion.active = flying;

endmodule

//--- verilog/hitDetect.sv
`timescale 1ns/1ps
`include "shotSettings.svh"

// result stage
// box overlap test once per frame, hit pulse and saturating score
module hitDetect
	import shotPkg::*;
(
	input	logic	clk,
	input	logic	resetN,
	input	logic	startOfFrame,	// one cycle tick per frame
	input	coordT	targetX,	// target top left corner
	input	coordT	targetY,
	output	logic	hit,	// one cycle pulse per collision
	output	scoreT	score,
	shotIf.hit	check
);

localparam logic signed [11:0] boxSize = 12'(`OBJECT_SIZE);
localparam scoreT scoreMax = '1;

// one extra bit so the corner difference cannot wrap
logic signed [11:0] diffX;
logic signed [11:0] diffY;
logic overlapX;
logic overlapY;

assign diffX = $signed({check.shotX[10], check.shotX}) - $signed({targetX[10], targetX});
assign diffY = $signed({check.shotY[10], check.shotY}) - $signed({targetY[10], targetY});

// equal sized boxes overlap when each corner distance is under one side
assign overlapX = (diffX < boxSize) && (diffX > -boxSize);
assign overlapY = (diffY < boxSize) && (diffY > -boxSize);

// only a flying shot can hit, and only on the frame tick
assign check.collision = startOfFrame && check.active && overlapX && overlapY;

always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		hit <= 1'b0;
		score <= '0;
	end
	else begin
		hit <= check.collision;	// collision lasts one cycle, so does hit
		if (check.collision && (score != scoreMax))
			score <= score + scoreT'(1);	// stops at 255
	end
end

endmodule

//--- verilog/shotGameTop.sv
`timescale 1ns/1ps

// shot game core with decode, execute and result stages on one interface
module shotGameTop
	import shotPkg::*;
(
	input	logic	clk,
	input	logic	resetN,
	input	logic	startOfFrame,	// one cycle tick per frame
	input	logic	fireButton,
	input	logic	leftButton,
	input	logic	rightButton,
	input	coordT	targetX,	// target top left corner
	input	coordT	targetY,
	output	coordT	shotX,	// shot top left corner in pixels
	output	coordT	shotY,
	output	logic	shotActive,
	output	logic	hit,	// one cycle per hit
	output	scoreT	score
);

shotIf bus ();

// button presses to launch strobe
fireControl fireCtl (
	.clk(clk),
	.resetN(resetN),
	.startOfFrame(startOfFrame),
	.fireButton(fireButton),
	.leftButton(leftButton),
	.rightButton(rightButton),
	.fire(bus.fire)
);

// shot position
shotLogic shotMove (
	.clk(clk),
	.resetN(resetN),
	.startOfFrame(startOfFrame),
	.motion(bus.motion)
);

// target test and score
hitDetect hitCheck (
	.clk(clk),
	.resetN(resetN),
	.startOfFrame(startOfFrame),
	.targetX(targetX),
	.targetY(targetY),
	.hit(hit),
	.score(score),
	.check(bus.hit)
);

assign shotX = bus.shotX;
assign shotY = bus.shotY;
assign shotActive = bus.active;

endmodule

//--- verification/clockGen.sv
`timescale 1ns/1ps

// testbench clock and power on reset
module clockGen #(
	parameter int halfPeriod = 50,	// ns, gives a 100 ns period
	parameter int resetCycles = 10
) (
	output logic clk,
	output logic resetN
);

initial begin
	clk = 1'b0;
	forever #(halfPeriod) clk = ~clk;
end

initial begin
	resetN = 1'b0;
	repeat (resetCycles) @(posedge clk);
	@(negedge clk);
	resetN = 1'b1;	// released away from the active edge
end

endmodule

//--- verification/shotGameTb.sv
`timescale 1ns/1ps
`include "shotSettings.svh"

// testbench for the shot game core
module shotGameTb
	import shotPkg::*;
();

localparam int framePeriod = 8;	// cycles from one frame tick to the next
localparam int flightMax = 60;	// frames, a full straight flight takes 44
localparam int randomFrames = 300;
localparam int burstHits = 260;	// more hits than the score can count
// worst case frame count of all phases below
localparam int frameBudget = 4 + 3 * (2 + flightMax + 8) + (3 + flightMax + 3)
	+ (2 + flightMax) + 5 + randomFrames + flightMax + 2 * burstHits + 1;
localparam int timeoutNs = frameBudget * framePeriod * 100 + 4000;	// plus reset and slack

// reference model state, one update per clock
typedef struct packed {
	logic pending;	// fire request waiting for a frame tick
	logic prevFire;
	logic active;
	logic hit;
	logic signed [31:0] fx;	// fixed point corner
	logic signed [31:0] fy;
	logic signed [31:0] speed;	// x drift per frame
	logic [31:0] score;
} modelT;

logic clk;
logic resetN;
logic startOfFrame;
logic fireButton;
logic leftButton;
logic rightButton;
coordT targetX;
coordT targetY;
coordT shotX;
coordT shotY;
logic shotActive;
logic hit;
scoreT score;

modelT model;
int checkCount;
int mismatchCount;
int failCount;
int seed;
int scoreBefore;

clockGen clocks (
	.clk(clk),
	.resetN(resetN)
);

shotGameTop u_dut (
	.clk(clk),
	.resetN(resetN),
	.startOfFrame(startOfFrame),
	.fireButton(fireButton),
	.leftButton(leftButton),
	.rightButton(rightButton),
	.targetX(targetX),
	.targetY(targetY),
	.shotX(shotX),
	.shotY(shotY),
	.shotActive(shotActive),
	.hit(hit),
	.score(score)
);

// fixed point to whole pixels, rounding toward minus infinity
function automatic int pixelOf(input int f);
	return f >>> `FIXED_SHIFT;
endfunction

function automatic modelT parkShot(input modelT m);
	modelT n;
	n = m;
	n.fx = `SCREEN_WIDTH << `FIXED_SHIFT;	// off screen, bottom right
	n.fy = `SCREEN_HEIGHT << `FIXED_SHIFT;
	n.active = 1'b0;
	return n;
endfunction

function automatic modelT resetModel();
	modelT m;
	m = '0;
	return parkShot(m);
endfunction

// next model state from this cycle's inputs
function automatic modelT refStep(input modelT s, input logic sof, input logic fireIn,
		input logic left, input logic right, input int tx, input int ty);
	modelT n;
	logic rise;
	logic launch;
	logic collide;
	int dx;
	int dy;
	int newY;
	n = s;
	rise = fireIn && !s.prevFire;
	dx = pixelOf(s.fx) - tx;
	dy = pixelOf(s.fy) - ty;
	collide = sof && s.active && (dx < `OBJECT_SIZE) && (dx > -`OBJECT_SIZE)
		&& (dy < `OBJECT_SIZE) && (dy > -`OBJECT_SIZE);
	launch = sof && s.pending && !s.active;	// a request meeting a flying shot is lost
	n.prevFire = fireIn;
	n.pending = rise || (s.pending && !sof);
	n.hit = collide;
	if (collide && (s.score < 255))
		n.score = s.score + 1;
	if (collide)
		n = parkShot(n);
	else if (launch) begin
		n.fx = `SHOT_START_X << `FIXED_SHIFT;
		n.fy = `SHOT_START_Y << `FIXED_SHIFT;
		n.active = 1'b1;
		if (right && !left)
			n.speed = `SHOT_SPEED_X;
		else if (left && !right)
			n.speed = -`SHOT_SPEED_X;
		else
			n.speed = 0;	// both or neither
	end
	else if (sof && s.active) begin
		newY = s.fy - `SHOT_SPEED_Y;
		if (pixelOf(newY) < `EXIT_Y)
			n = parkShot(n);	// left through the top
		else begin
			n.fx = s.fx + s.speed;
			n.fy = newY;
		end
	end
	return n;
endfunction

task automatic checkSignal(input string name, input int actual, input int expected);
	checkCount++;
	assert (actual == expected) else begin
		mismatchCount++;
		$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
	end
endtask

task automatic expectTrue(input bit cond, input string what);
	checkCount++;
	assert (cond) else begin
		failCount++;
		$display("Failure at %0t ns: %s", $time, what);
	end
endtask

// one frame period, tick first, optional two cycle fire press after it
task automatic frameCycle(input bit press);
	@(negedge clk);
	startOfFrame = 1'b1;
	@(negedge clk);
	startOfFrame = 1'b0;
	fireButton = press;
	repeat (2) @(negedge clk);
	fireButton = 1'b0;
	repeat (framePeriod - 4) @(negedge clk);
endtask

// press in one frame, launch at the next tick, new shot visible on return
task automatic launchShot(input bit left, input bit right);
	leftButton = left;
	rightButton = right;
	frameCycle(1'b1);
	frameCycle(1'b0);
endtask

task automatic flyUntilParked(input int limit);
	int n;
	n = 0;
	while (shotActive && (n < limit)) begin
		frameCycle(1'b0);
		n++;
	end
	expectTrue(!shotActive, $sformatf("shot still flying after %0d frames", limit));
endtask

task automatic randomFrame();
	int r;
	leftButton = 1'($urandom % 2);
	rightButton = 1'($urandom % 2);
	r = $urandom % 160;
	targetX = coordT'(200 + r);	// around the launch column
	r = $urandom % 260;
	targetY = coordT'(r - 40);	// anywhere on the flight path
	frameCycle(($urandom % 3) == 0);
endtask

// model follows the DUT clock, inputs are stable at the rising edge
always @(posedge clk or negedge resetN) begin
	if (!resetN)
		model <= resetModel();
	else
		model <= refStep(model, startOfFrame, fireButton, leftButton, rightButton,
			targetX, targetY);
end

// compared on every falling edge, so holding between ticks and the hit width are covered
always @(negedge clk) begin
	if (resetN) begin
		checkSignal("shotX", shotX, pixelOf(model.fx));
		checkSignal("shotY", shotY, pixelOf(model.fy));
		checkSignal("shotActive", shotActive, model.active);
		checkSignal("hit", hit, model.hit);
		checkSignal("score", score, model.score);
	end
end

initial begin
	#(timeoutNs);
	$display("Timeout: frame sequence not finished after %0d ns", timeoutNs);
	$display("checks %0d, mismatches %0d, other failures %0d",
		checkCount, mismatchCount, failCount);
	$display("TEST FAILED");
	$finish;
end

initial begin
	startOfFrame = 1'b0;
	fireButton = 1'b0;
	leftButton = 1'b0;
	rightButton = 1'b0;
	targetX = coordT'(20);	// far from any flight path
	targetY = coordT'(400);
	checkCount = 0;
	mismatchCount = 0;
	failCount = 0;
	seed = 32'ha574_ad04;
	void'($urandom(seed));
	@(posedge resetN);

	// idle frames, shot stays parked
	repeat (4) frameCycle(1'b0);
	checkSignal("shotX", shotX, `SCREEN_WIDTH);
	checkSignal("shotY", shotY, `SCREEN_HEIGHT);
	checkSignal("shotActive", shotActive, 0);
	checkSignal("score", score, 0);

	// straight flight up to the top edge
	launchShot(1'b0, 1'b0);
	checkSignal("shotX", shotX, `SHOT_START_X);
	checkSignal("shotY", shotY, `SHOT_START_Y);
	frameCycle(1'b0);
	checkSignal("shotX", shotX, `SHOT_START_X);
	checkSignal("shotY", shotY, `SHOT_START_Y - (`SHOT_SPEED_Y >> `FIXED_SHIFT));
	flyUntilParked(flightMax);

	// drift right then left, pixel x follows the truncated value
	launchShot(1'b0, 1'b1);
	repeat (8) frameCycle(1'b0);
	checkSignal("shotX", shotX, ((`SHOT_START_X << `FIXED_SHIFT) + 8 * `SHOT_SPEED_X) >>> 6);
	flyUntilParked(flightMax);
	launchShot(1'b1, 1'b0);
	repeat (8) frameCycle(1'b0);
	checkSignal("shotX", shotX, ((`SHOT_START_X << `FIXED_SHIFT) - 8 * `SHOT_SPEED_X) >>> 6);
	flyUntilParked(flightMax);

	// press during flight is thrown away
	launchShot(1'b0, 1'b0);
	frameCycle(1'b1);
	flyUntilParked(flightMax);
	repeat (3) frameCycle(1'b0);
	expectTrue(!shotActive, "a press made during a flight launched a shot later");

	// target on the straight path
	targetX = coordT'(`SHOT_START_X);
	targetY = coordT'(100);
	scoreBefore = score;
	launchShot(1'b0, 1'b0);
	flyUntilParked(flightMax);
	checkSignal("score", score, scoreBefore + 1);

	// collision in the same tick as a waiting press
	targetY = coordT'(`SHOT_START_Y - 5);
	scoreBefore = score;
	frameCycle(1'b1);
	frameCycle(1'b1);	// launch, then a second press waits
	frameCycle(1'b0);	// hit, the waiting press is dropped
	checkSignal("shotActive", shotActive, 0);
	checkSignal("score", score, scoreBefore + 1);
	repeat (2) frameCycle(1'b0);
	expectTrue(!shotActive, "a press pending at a collision launched a shot");

	// random frames against the model
	for (int i = 0; i < randomFrames; i++)
		randomFrame();
	flyUntilParked(flightMax);

	// target on the launch point, every launch is a hit on the next tick
	targetX = coordT'(`SHOT_START_X);
	targetY = coordT'(`SHOT_START_Y);
	leftButton = 1'b0;
	rightButton = 1'b0;
	repeat (burstHits) begin
		frameCycle(1'b1);
		frameCycle(1'b0);
	end
	frameCycle(1'b0);
	checkSignal("score", score, 255);

	$display("checks %0d, mismatches %0d, other failures %0d",
		checkCount, mismatchCount, failCount);
	if ((mismatchCount == 0) && (failCount == 0))
		$display("TEST OK");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

//--- flist.f
+incdir+verilog
verilog/shotPkg.sv
verilog/shotIf.sv
verilog/fireControl.sv
verilog/shotLogic.sv
verilog/hitDetect.sv
verilog/shotGameTop.sv
verification/clockGen.sv
verification/shotGameTb.sv
